// ==== qeciphy_defines.svh ====
// QECIPHY transmit framing constants
// Frame geometry, fixed slot words and CRC-16 parameters
`ifndef QECIPHY_DEFINES_SVH
`define QECIPHY_DEFINES_SVH

// Slots per frame, slot 0 is the FAW
`define QECIPHY_FRAME_SLOTS 64

// Data slots covered by one CRC word, so a CRC slot every 7 slots
`define QECIPHY_CRC_GROUP 6

// Alignment pattern for bits 63:8 of the FAW word
`define QECIPHY_FAW_PATTERN 56'hA5C3_96F0_3C5A_E1

// Filler word for a data slot with nothing to send
`define QECIPHY_IDLE_WORD 64'hB7B7_B7B7_B7B7_B7B7

// Upper 48 bits of every CRC word
`define QECIPHY_CRC_TAG 48'hC3C3_5A5A_C3C3

// CRC-16 polynomial and start value
`define QECIPHY_CRC_POLY 16'h1021
`define QECIPHY_CRC_INIT 16'hFFFF

`endif

// ==== qeciphy_pkg.sv ====
// QECIPHY transmit types
// Slot markers and one-hot link mode shared by the framing blocks
package qeciphy_pkg;

   // Position of the current slot within the frame
   typedef struct packed {
      // Slot 0, carries the FAW
      logic faw;
      // Slot carries a CRC word
      logic crc;
      // Last slot of the frame
      logic frame_end;
   } tx_slot_t;

   // Link mode, exactly one bit high
   typedef struct packed {
      // Nothing is sent, line words are zero
      logic off;
      // Framing runs, data slots carry the idle word
      logic idle;
      // Framing runs and user data is accepted
      logic active;
   } tx_mode_t;

endpackage

// ==== qeciphy_tx_slot_counter.sv ====
// QECIPHY transmit slot counter
// Tracks the slot position in the frame and marks FAW, CRC and frame-end slots
`timescale 1ns/1ps
`include "qeciphy_defines.svh"

module qeciphy_tx_slot_counter
   import qeciphy_pkg::*;
(
   input  logic     clk_i,
   input  logic     rst_n_i,
   output tx_slot_t slot_o
);

   localparam int frame_w = $clog2(`QECIPHY_FRAME_SLOTS);
   localparam int group_w = $clog2(`QECIPHY_CRC_GROUP + 1);

   logic [frame_w-1:0] frame_cnt_q;
   logic [group_w-1:0] group_cnt_q;

   // Markers decode straight from the counters
   always_comb begin
      slot_o.faw       = (frame_cnt_q == '0);
      slot_o.crc       = (group_cnt_q == group_w'(`QECIPHY_CRC_GROUP));
      slot_o.frame_end = (frame_cnt_q == frame_w'(`QECIPHY_FRAME_SLOTS - 1));
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         frame_cnt_q <= '0;
         group_cnt_q <= '0;
      end else begin
         if (slot_o.frame_end) begin
            frame_cnt_q <= '0;
         end else begin
            frame_cnt_q <= frame_cnt_q + 1'b1;
         end

         // Group count is the number of data slots since the last FAW or CRC slot
         if (slot_o.faw || slot_o.crc) begin
            group_cnt_q <= '0;
         end else begin
            group_cnt_q <= group_cnt_q + 1'b1;
         end
      end
   end

endmodule

// ==== qeciphy_tx_mode_ctrl.sv ====
// QECIPHY transmit mode controller
// Decodes the enable levels into a one-hot mode that only changes between frames
`timescale 1ns/1ps

module qeciphy_tx_mode_ctrl
   import qeciphy_pkg::*;
(
   input  logic     clk_i,
   input  logic     rst_n_i,
   input  tx_slot_t slot_i,
   input  logic     tx_en_i,
   input  logic     data_en_i,
   output tx_mode_t mode_o
);

   tx_mode_t mode_d;
   tx_mode_t mode_q;

   // Requested mode from the current enable levels
   always_comb begin
      mode_d = '0;
      if (!tx_en_i) begin
         mode_d.off = 1'b1;
      end else if (data_en_i) begin
         mode_d.active = 1'b1;
      end else begin
         mode_d.idle = 1'b1;
      end
   end

   // Load in the last slot so the new mode starts with the next FAW
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         mode_q <= '{off: 1'b1, idle: 1'b0, active: 1'b0};
      end else if (slot_i.frame_end) begin
         mode_q <= mode_d;
      end
   end

   assign mode_o = mode_q;

endmodule

// ==== qeciphy_tx_crc.sv ====
// QECIPHY transmit CRC-16
// Running CRC over slot words, MSB first, restarted per CRC group
`timescale 1ns/1ps
`include "qeciphy_defines.svh"

module qeciphy_tx_crc (
   input  logic        clk_i,
   input  logic        rst_n_i,
   input  logic [63:0] word_i,
   input  logic        word_valid_i,
   input  logic        restart_i,
   output logic [15:0] crc_o
);

   logic [15:0] crc_q;

   // Folds one 64-bit word into the CRC, one bit at a time from bit 63 down
   function automatic logic [15:0] crc16_word(input logic [15:0] crc_in,
                                              input logic [63:0] word);
      logic [15:0] crc;
      logic        feedback;
      crc = crc_in;
      for (int i = 63; i >= 0; i--) begin
         feedback = crc[15] ^ word[i];
         crc      = {crc[14:0], 1'b0};
         if (feedback) begin
            crc = crc ^ `QECIPHY_CRC_POLY;
         end
      end
      return crc;
   endfunction

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         crc_q <= `QECIPHY_CRC_INIT;
      end else if (restart_i) begin
         // Restart has priority, FAW and CRC slots never feed a word
         crc_q <= `QECIPHY_CRC_INIT;
      end else if (word_valid_i) begin
         crc_q <= crc16_word(crc_q, word_i);
      end
   end

   assign crc_o = crc_q;

endmodule

// ==== qeciphy_tx_packet_gen.sv ====
// QECIPHY transmit packet generator
// Picks the FAW, CRC, idle or data word for each slot and registers it onto the line
`timescale 1ns/1ps
`include "qeciphy_defines.svh"

module qeciphy_tx_packet_gen (
   input  logic        clk_i,
   input  logic        rst_n_i,
   input  logic        faw_boundary_i,
   input  logic        crc_boundary_i,
   input  logic [63:0] s_axis_tdata_i,
   input  logic        s_axis_tvalid_i,
   output logic        s_axis_tready_o,
   output logic [63:0] m_axis_tdata_o,
   output logic        m_axis_tdata_isfaw_o,
   input  logic        tx_off_i,
   input  logic        tx_idle_i,
   input  logic        tx_active_i,
   input  logic        rx_rdy_i
);

   logic        data_slot;
   logic        xfer;
   logic        crc_feed;
   logic        crc_restart;
   logic [15:0] crc_value;
   logic [63:0] data_word;
   logic [63:0] slot_word;
   logic        slot_isfaw;

   assign data_slot = !faw_boundary_i && !crc_boundary_i;

   // Only back-pressure is slot type and mode, never valid
   assign s_axis_tready_o = data_slot && tx_active_i;
   assign xfer            = s_axis_tready_o && s_axis_tvalid_i;

   // Data slot payload, idle filler when nothing transfers
   assign data_word = xfer ? s_axis_tdata_i : `QECIPHY_IDLE_WORD;

   // Every data slot sent on a live link is covered by the CRC
   assign crc_feed    = data_slot && (tx_idle_i || tx_active_i);
   assign crc_restart = faw_boundary_i || crc_boundary_i;

   qeciphy_tx_crc u_crc (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .word_i       (data_word),
      .word_valid_i (crc_feed),
      .restart_i    (crc_restart),
      .crc_o        (crc_value)
   );

   always_comb begin
      slot_word  = '0;
      slot_isfaw = 1'b0;
      // Off mode leaves the line at zero in every slot
      if (!tx_off_i) begin
         if (faw_boundary_i) begin
            slot_word  = {`QECIPHY_FAW_PATTERN, 7'b0, rx_rdy_i};
            slot_isfaw = 1'b1;
         end else if (crc_boundary_i) begin
            slot_word = {`QECIPHY_CRC_TAG, crc_value};
         end else begin
            slot_word = data_word;
         end
      end
   end

   // Slot word goes out one cycle after its slot
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         m_axis_tdata_o       <= '0;
         m_axis_tdata_isfaw_o <= 1'b0;
      end else begin
         m_axis_tdata_o       <= slot_word;
         m_axis_tdata_isfaw_o <= slot_isfaw;
      end
   end

endmodule

// ==== qeciphy_tx_top.sv ====
// QECIPHY transmit framing top
// Slot counter and mode controller driving the packet generator
`timescale 1ns/1ps

module qeciphy_tx_top
   import qeciphy_pkg::*;
(
   input  logic        clk_i,
   input  logic        rst_n_i,
   input  logic        tx_en_i,
   input  logic        data_en_i,
   input  logic        rx_rdy_i,
   input  logic [63:0] s_axis_tdata_i,
   input  logic        s_axis_tvalid_i,
   output logic        s_axis_tready_o,
   output logic [63:0] m_axis_tdata_o,
   output logic        m_axis_tdata_isfaw_o
);

   tx_slot_t slot;
   tx_mode_t mode;
   logic     faw_boundary;
   logic     crc_boundary;
   logic     tx_off;
   logic     tx_idle;
   logic     tx_active;

   qeciphy_tx_slot_counter u_slot_counter (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .slot_o  (slot)
   );

   qeciphy_tx_mode_ctrl u_mode_ctrl (
      .clk_i     (clk_i),
      .rst_n_i   (rst_n_i),
      .slot_i    (slot),
      .tx_en_i   (tx_en_i),
      .data_en_i (data_en_i),
      .mode_o    (mode)
   );

   // Split the structs into the packet generator's single-bit controls
   assign faw_boundary = slot.faw;
   assign crc_boundary = slot.crc;
   assign tx_off       = mode.off;
   assign tx_idle      = mode.idle;
   assign tx_active    = mode.active;

   qeciphy_tx_packet_gen u_packet_gen (
      .clk_i                (clk_i),
      .rst_n_i              (rst_n_i),
      .faw_boundary_i       (faw_boundary),
      .crc_boundary_i       (crc_boundary),
      .s_axis_tdata_i       (s_axis_tdata_i),
      .s_axis_tvalid_i      (s_axis_tvalid_i),
      .s_axis_tready_o      (s_axis_tready_o),
      .m_axis_tdata_o       (m_axis_tdata_o),
      .m_axis_tdata_isfaw_o (m_axis_tdata_isfaw_o),
      .tx_off_i             (tx_off),
      .tx_idle_i            (tx_idle),
      .tx_active_i          (tx_active),
      .rx_rdy_i             (rx_rdy_i)
   );

endmodule

// ==== tb_qeciphy_tx.sv ====
// QECIPHY transmit framing testbench
// Drives enables and stream data, checks every line word against a slot-level reference
`timescale 1ns/1ps
`include "qeciphy_defines.svh"

module tb_qeciphy_tx;

   localparam int mode_off    = 0;
   localparam int mode_idle   = 1;
   localparam int mode_active = 2;

   logic        clk_i;
   logic        rst_n_i;
   logic        tx_en_i;
   logic        data_en_i;
   logic        rx_rdy_i;
   logic [63:0] s_axis_tdata_i;
   logic        s_axis_tvalid_i;
   logic        s_axis_tready_o;
   logic [63:0] m_axis_tdata_o;
   logic        m_axis_tdata_isfaw_o;

   // Reference state, advanced at each falling edge
   int          ref_slot = 0;
   int          ref_mode = mode_off;
   logic [15:0] ref_crc = `QECIPHY_CRC_INIT;
   logic [64:0] exp_line = '0;
   logic        xfer_now = 1'b0;
   int          checks = 0;
   int          errors = 0;
   int          faw_seen = 0;
   int          crc_seen = 0;
   int          accepted = 0;

   qeciphy_tx_top u_qeciphy_tx_top (
      .clk_i                (clk_i),
      .rst_n_i              (rst_n_i),
      .tx_en_i              (tx_en_i),
      .data_en_i            (data_en_i),
      .rx_rdy_i             (rx_rdy_i),
      .s_axis_tdata_i       (s_axis_tdata_i),
      .s_axis_tvalid_i      (s_axis_tvalid_i),
      .s_axis_tready_o      (s_axis_tready_o),
      .m_axis_tdata_o       (m_axis_tdata_o),
      .m_axis_tdata_isfaw_o (m_axis_tdata_isfaw_o)
   );

   initial begin
      clk_i = 1'b0;
      forever begin
         #4 clk_i = ~clk_i;
      end
   end

   // CRC-16 over one word, MSB first
   function automatic logic [15:0] crc16_ref(input logic [15:0] crc_in, input logic [63:0] word);
      logic [15:0] crc;
      crc = crc_in;
      for (int b = 63; b >= 0; b--) begin
         if (crc[15] ^ word[b]) begin
            crc = (crc << 1) ^ `QECIPHY_CRC_POLY;
         end else begin
            crc = crc << 1;
         end
      end
      return crc;
   endfunction

   function automatic int decode_mode(input logic tx_en, input logic data_en);
      if (!tx_en) begin
         return mode_off;
      end
      return data_en ? mode_active : mode_idle;
   endfunction

   // Expected {isfaw, word} for one slot
   function automatic logic [64:0] expected_line(input int slot, input int mode,
                                                 input logic rdy, input logic xfer,
                                                 input logic [63:0] data,
                                                 input logic [15:0] crc);
      if (mode == mode_off) begin
         return '0;
      end
      if (slot == 0) begin
         return {1'b1, `QECIPHY_FAW_PATTERN, 7'b0, rdy};
      end
      if (slot % 7 == 0) begin
         return {1'b0, `QECIPHY_CRC_TAG, crc};
      end
      return xfer ? {1'b0, data} : {1'b0, `QECIPHY_IDLE_WORD};
   endfunction

   // Compare the line word of the previous slot, then step the reference
   always @(negedge clk_i) begin
      logic        data_slot;
      logic        ready_exp;
      logic [63:0] word;
      checks++;
      assert (m_axis_tdata_o == exp_line[63:0]) else begin
         $display("FAILED t=%0t m_axis_tdata_o got %h expected %h",
                  $time, m_axis_tdata_o, exp_line[63:0]);
         errors++;
      end
      assert (m_axis_tdata_isfaw_o == exp_line[64]) else begin
         $display("FAILED t=%0t m_axis_tdata_isfaw_o got %b expected %b",
                  $time, m_axis_tdata_isfaw_o, exp_line[64]);
         errors++;
      end
      // Line words as the DUT sent them
      if (m_axis_tdata_isfaw_o) begin
         faw_seen++;
      end
      if (m_axis_tdata_o[63:16] == `QECIPHY_CRC_TAG) begin
         crc_seen++;
      end
      // Slot 0 is the FAW and every seventh slot a CRC word
      data_slot = (ref_slot % 7) != 0;
      ready_exp = rst_n_i && data_slot && (ref_mode == mode_active);
      assert (s_axis_tready_o == ready_exp) else begin
         $display("FAILED t=%0t s_axis_tready_o got %b expected %b",
                  $time, s_axis_tready_o, ready_exp);
         errors++;
      end
      xfer_now = ready_exp && s_axis_tvalid_i;
      if (!rst_n_i) begin
         ref_slot = 0;
         ref_mode = mode_off;
         ref_crc  = `QECIPHY_CRC_INIT;
         exp_line = '0;
      end else begin
         exp_line = expected_line(ref_slot, ref_mode, rx_rdy_i, xfer_now, s_axis_tdata_i,
                                  ref_crc);
         // Transfers as seen on the DUT handshake
         if (s_axis_tready_o && s_axis_tvalid_i) begin
            accepted++;
         end
         word = xfer_now ? s_axis_tdata_i : `QECIPHY_IDLE_WORD;
         if (!data_slot) begin
            ref_crc = `QECIPHY_CRC_INIT;
         end else if (ref_mode != mode_off) begin
            ref_crc = crc16_ref(ref_crc, word);
         end
         if (ref_slot == `QECIPHY_FRAME_SLOTS - 1) begin
            ref_mode = decode_mode(tx_en_i, data_en_i);
         end
         ref_slot = (ref_slot + 1) % `QECIPHY_FRAME_SLOTS;
      end
   end

   task automatic next_cycle();
      @(posedge clk_i);
      #1;
   endtask

   // Source holds its word until it transfers
   task automatic run_traffic(input int cycles);
      repeat (cycles) begin
         next_cycle();
         if (!s_axis_tvalid_i || xfer_now) begin
            s_axis_tvalid_i = ($urandom_range(99) < 70);
            s_axis_tdata_i  = {$urandom, $urandom};
         end
      end
   endtask

   task automatic wait_faw_line();
      int n;
      n = 0;
      do begin
         next_cycle();
         n++;
      end while (!m_axis_tdata_isfaw_o && n < 200);
      if (!m_axis_tdata_isfaw_o) begin
         $display("Timed out after %0d cycles waiting for a FAW word on the line", n);
         errors++;
      end
   endtask

   task automatic report_test(input string name, input int chk_mark, input int err_mark);
      $display("Test %s: %0d cycles compared, %0d errors, %s", name, checks - chk_mark,
               errors - err_mark, (errors == err_mark) ? "passed" : "failed");
   endtask

   initial begin
      int chk_mark;
      int err_mark;
      int acc_mark;
      int crc_mark;
      void'($urandom(37073));
      rst_n_i         = 1'b0;
      tx_en_i         = 1'b0;
      data_en_i       = 1'b0;
      rx_rdy_i        = 1'b0;
      s_axis_tdata_i  = '0;
      s_axis_tvalid_i = 1'b0;
      repeat (10) begin
         next_cycle();
      end
      rst_n_i = 1'b1;

      chk_mark = checks;
      err_mark = errors;
      run_traffic(70);
      report_test("off mode after reset", chk_mark, err_mark);

      chk_mark = checks;
      err_mark = errors;
      tx_en_i  = 1'b1;
      for (int f = 0; f < 4; f++) begin
         rx_rdy_i = f[0];
         wait_faw_line();
         assert (m_axis_tdata_o[0] == rx_rdy_i) else begin
            $display("FAILED t=%0t m_axis_tdata_o[0] got %b expected %b",
                     $time, m_axis_tdata_o[0], rx_rdy_i);
            errors++;
         end
      end
      report_test("FAW word and rx ready", chk_mark, err_mark);

      chk_mark  = checks;
      err_mark  = errors;
      acc_mark  = accepted;
      data_en_i = 1'b1;
      run_traffic(3 * `QECIPHY_FRAME_SLOTS);
      assert (accepted != acc_mark) else begin
         $display("No input word was accepted in active mode");
         errors++;
      end
      report_test("active data with valid gaps", chk_mark, err_mark);

      chk_mark = checks;
      err_mark = errors;
      crc_mark = crc_seen;
      run_traffic(2 * `QECIPHY_FRAME_SLOTS);
      assert (crc_seen - crc_mark >= 18) else begin
         $display("Too few CRC words in two active frames: %0d", crc_seen - crc_mark);
         errors++;
      end
      report_test("CRC words", chk_mark, err_mark);

      chk_mark  = checks;
      err_mark  = errors;
      data_en_i = 1'b0;
      run_traffic(3 * `QECIPHY_FRAME_SLOTS);
      report_test("idle mode", chk_mark, err_mark);

      chk_mark = checks;
      err_mark = errors;
      wait_faw_line();
      run_traffic(20);
      // Valid held high so an early mode switch would show as a transfer
      s_axis_tvalid_i = 1'b1;
      data_en_i       = 1'b1;
      acc_mark        = accepted;
      wait_faw_line();
      assert (accepted == acc_mark) else begin
         $display("Input data was accepted before the new frame started");
         errors++;
      end
      run_traffic(30);
      tx_en_i = 1'b0;
      run_traffic(100);
      report_test("mid-frame enable change", chk_mark, err_mark);

      $display("Cycles compared: %0d, errors: %0d, FAW words: %0d, CRC words: %0d, accepted: %0d",
               checks, errors, faw_seen, crc_seen, accepted);
      if (errors == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

endmodule

// ==== sim.f ====
+incdir+.
qeciphy_pkg.sv
qeciphy_tx_slot_counter.sv
qeciphy_tx_mode_ctrl.sv
qeciphy_tx_crc.sv
qeciphy_tx_packet_gen.sv
qeciphy_tx_top.sv
tb_qeciphy_tx.sv

// ==== Bender.yml ====
package:
  name: qeciphy_tx

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - qeciphy_pkg.sv
      - qeciphy_tx_slot_counter.sv
      - qeciphy_tx_mode_ctrl.sv
      - qeciphy_tx_crc.sv
      - qeciphy_tx_packet_gen.sv
      - qeciphy_tx_top.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_qeciphy_tx.sv
